//--- design/ioMapPkg.sv
package ioMapPkg;

	////////////////////////////////////////////////////////////////////////////
	// Address regions, selected by the top two address bits
	////////////////////////////////////////////////////////////////////////////

	// Nothing mapped here
	localparam logic [1:0] regionUnused = 2'b00;
	// LED output register
	localparam logic [1:0] regionLed = 2'b01;
	// Sound command port, write only
	localparam logic [1:0] regionSound = 2'b10;
	// Game pad buttons, read only
	localparam logic [1:0] regionPad = 2'b11;

	////////////////////////////////////////////////////////////////////////////
	// Bus and pad sizes
	////////////////////////////////////////////////////////////////////////////

	// Processor data word
	localparam int defDataWidth = 8;
	// Processor address, region bits included
	localparam int defAddrBits = 14;

	// Four pads packed into one 32-bit read word
	localparam int padCount = 4;
	// A, B, Select, Start, Up, Down, Left, Right
	localparam int padBits = 8;

endpackage

//--- design/soundPkg.sv
package soundPkg;

	////////////////////////////////////////////////////////////////////////////
	// Command codes
	////////////////////////////////////////////////////////////////////////////

	localparam int cmdWidth = 2;

	// Short falling sweep on melody only
	localparam logic [cmdWidth-1:0] cmdLaser = 2'b01;
	// Slow descending tune on melody and bass
	localparam logic [cmdWidth-1:0] cmdDeath = 2'b11;
	// Codes 00 and 10 play silence for one command length

	////////////////////////////////////////////////////////////////////////////
	// Note tables
	////////////////////////////////////////////////////////////////////////////

	// Every command is this many notes long
	localparam int notesPerCmd = 4;

	// Half-periods in clock cycles, entry 0 plays first
	// Longer half-period means lower pitch
	localparam logic [notesPerCmd-1:0][15:0] laserHalfPeriod =
		{16'd768, 16'd512, 16'd384, 16'd256};

	// Death melody walks down
	localparam logic [notesPerCmd-1:0][15:0] deathMelodyHalf =
		{16'd1024, 16'd768, 16'd640, 16'd512};

	// Bass holds two low notes under the melody
	localparam logic [notesPerCmd-1:0][15:0] deathBassHalf =
		{16'd1024, 16'd1024, 16'd768, 16'd768};

	////////////////////////////////////////////////////////////////////////////
	// Timing and queue defaults
	////////////////////////////////////////////////////////////////////////////

	// About an eighth of a second at 50 MHz
	localparam int defNoteCycles = 6250000;
	localparam int defQueueDepth = 4;

endpackage

//--- design/nesController.sv
`timescale 1ns/1ps

module nesController #(
	parameter int tickDiv = 250
) (
	input  logic clk,
	input  logic rstN,
	input  logic data,
	output logic latch,
	output logic pulse,
	output logic [ioMapPkg::padBits-1:0] buttons
);

	// Divider width, at least one bit
	localparam int divW = (tickDiv > 1) ? $clog2(tickDiv) : 1;

	// Frame landmarks in ticks
	localparam logic [4:0] lastTick = 5'd31;
	localparam logic [4:0] firstPulseTick = 5'd2;
	localparam logic [4:0] lastPulseTick = 5'd14;
	localparam logic [4:0] firstSampleTick = 5'd1;
	localparam logic [4:0] lastSampleTick = 5'd15;
	localparam logic [4:0] byteTick = 5'd17;

	logic [divW-1:0] divCnt;
	logic tickEnd;
	logic [4:0] tickCnt;
	logic sampleTick;
	logic [ioMapPkg::padBits-1:0] shiftReg;

	////////////////////////////////////////////////////////////////////////////
	// Tick timing
	////////////////////////////////////////////////////////////////////////////

	// Last clock of the current tick
	assign tickEnd = (divCnt == divW'(tickDiv - 1));

	always_ff @(posedge clk)
	begin
		if (!rstN)
			divCnt <= '0;
		else if (tickEnd)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	// Reset parks the counter in the idle tail of a frame
	// so latch and pulse stay low until tick 0 comes round
	always_ff @(posedge clk)
	begin
		if (!rstN)
			tickCnt <= lastTick;
		else if (tickEnd)
			tickCnt <= tickCnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pad strobes
	////////////////////////////////////////////////////////////////////////////

	// Latch loads the pad's shift register
	assign latch = (tickCnt == 5'd0);

	// Even ticks 2 to 14 advance the pad to the next button
	assign pulse = !tickCnt[0] && (tickCnt >= firstPulseTick) && (tickCnt <= lastPulseTick);

	// Odd ticks 1 to 15, one per button
	assign sampleTick = tickCnt[0] && (tickCnt >= firstSampleTick)
		&& (tickCnt <= lastSampleTick);

	////////////////////////////////////////////////////////////////////////////
	// Button capture
	////////////////////////////////////////////////////////////////////////////

	// Line is active low, store pressed as 1
	// First sample ends up in bit 0 after eight shifts
	always_ff @(posedge clk)
	begin
		if (tickEnd && sampleTick)
			shiftReg <= {~data, shiftReg[ioMapPkg::padBits-1:1]};
	end

	// Publish the full byte once per frame
	always_ff @(posedge clk)
	begin
		if (!rstN)
			buttons <= '0;
		else if (tickEnd && (tickCnt == byteTick))
			buttons <= shiftReg;
	end

endmodule

//--- design/soundCmdQueue.sv
`timescale 1ns/1ps

module soundCmdQueue #(
	parameter int depth = 4,
	parameter int width = 2
) (
	input  logic clk,
	input  logic rstN,
	input  logic push,
	input  logic [width-1:0] dataIn,
	input  logic pop,
	output logic [width-1:0] dataOut,
	output logic empty
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic full;
	logic doPush;
	logic doPop;

	assign empty = (count == '0);
	assign full = (count == cntW'(depth));

	// Full queue drops the push, empty queue ignores the pop
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	// Oldest entry, valid while not empty
	assign dataOut = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= dataIn;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at depth, which need not be a power of two
			if (doPush)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			// Push and pop together leave the count alone
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

//--- design/soundGenerator.sv
`timescale 1ns/1ps

module soundGenerator #(
	parameter int noteCycles = 6250000,
	parameter int halfScale = 0
) (
	input  logic clk,
	input  logic rstN,
	input  logic [soundPkg::cmdWidth-1:0] cmd,
	input  logic cmdReady,
	output logic cmdPop,
	output logic soundMelody,
	output logic soundBass
);

	localparam int noteW = $clog2(noteCycles + 1);
	localparam int idxW = $clog2(soundPkg::notesPerCmd);

	logic busy;
	logic [soundPkg::cmdWidth-1:0] cmdReg;
	logic [idxW-1:0] noteIdx;
	logic [noteW-1:0] noteCnt;
	logic noteEnd;
	logic lastNote;
	logic [15:0] melCnt;
	logic [15:0] bassCnt;
	logic [15:0] melHalf;
	logic [15:0] bassHalf;
	logic [15:0] melLimit;
	logic [15:0] bassLimit;
	logic melOn;
	logic bassOn;

	// Take the head of the queue as soon as we are free
	assign cmdPop = !busy && cmdReady;

	assign noteEnd = (noteCnt == noteW'(noteCycles - 1));
	assign lastNote = (noteIdx == idxW'(soundPkg::notesPerCmd - 1));

	////////////////////////////////////////////////////////////////////////////
	// Tone selection
	////////////////////////////////////////////////////////////////////////////

	// Laser and death both drive melody, only death drives bass
	assign melOn = (cmdReg == soundPkg::cmdLaser) || (cmdReg == soundPkg::cmdDeath);
	assign bassOn = (cmdReg == soundPkg::cmdDeath);

	// Table half-periods, scaled down for short tones
	assign melHalf = ((cmdReg == soundPkg::cmdLaser) ? soundPkg::laserHalfPeriod[noteIdx]
		: soundPkg::deathMelodyHalf[noteIdx]) >> halfScale;
	assign bassHalf = soundPkg::deathBassHalf[noteIdx] >> halfScale;

	// Terminal counts, zero half-period toggles every cycle
	assign melLimit = (melHalf == '0) ? '0 : melHalf - 1'b1;
	assign bassLimit = (bassHalf == '0) ? '0 : bassHalf - 1'b1;

	always_ff @(posedge clk)
	begin
		if (cmdPop)
			cmdReg <= cmd;
	end

	////////////////////////////////////////////////////////////////////////////
	// Command sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			noteIdx <= '0;
			noteCnt <= '0;
		end
		else if (cmdPop)
		begin
			busy <= 1'b1;
			noteIdx <= '0;
			noteCnt <= '0;
		end
		else if (busy)
		begin
			if (noteEnd)
			begin
				noteCnt <= '0;
				noteIdx <= noteIdx + 1'b1;
				// Four notes done, back to idle
				if (lastNote)
					busy <= 1'b0;
			end
			else
				noteCnt <= noteCnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Square waves
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN || cmdPop || !busy || (noteEnd && lastNote))
		begin
			// Pins idle low between commands
			melCnt <= '0;
			bassCnt <= '0;
			soundMelody <= 1'b0;
			soundBass <= 1'b0;
		end
		else if (noteEnd)
		begin
			// Each note starts its waves from a fresh count
			melCnt <= '0;
			bassCnt <= '0;
		end
		else
		begin
			if (melCnt >= melLimit)
			begin
				melCnt <= '0;
				soundMelody <= melOn ? ~soundMelody : 1'b0;
			end
			else
				melCnt <= melCnt + 1'b1;
			if (bassCnt >= bassLimit)
			begin
				bassCnt <= '0;
				soundBass <= bassOn ? ~soundBass : 1'b0;
			end
			else
				bassCnt <= bassCnt + 1'b1;
		end
	end

endmodule

//--- design/ioMemory.sv
`timescale 1ns/1ps

module ioMemory #(
	parameter int dataWidth = ioMapPkg::defDataWidth,
	parameter int addrBits = ioMapPkg::defAddrBits,
	parameter int tickDiv = 250,
	parameter int noteCycles = soundPkg::defNoteCycles,
	parameter int queueDepth = soundPkg::defQueueDepth,
	parameter int halfScale = 0
) (
	input  logic clk,
	input  logic rstN,
	input  logic en,
	input  logic memWrite,
	input  logic [addrBits-1:0] address,
	input  logic [dataWidth-1:0] writeData,
	input  logic [ioMapPkg::padCount-1:0] padData,
	output logic [31:0] ioData,
	output logic [ioMapPkg::padCount-1:0] padLatch,
	output logic [ioMapPkg::padCount-1:0] padPulse,
	output logic [dataWidth-1:0] leds,
	output logic soundMelody,
	output logic soundBass
);

	logic [1:0] region;
	logic writeEn;
	logic [ioMapPkg::padCount-1:0][ioMapPkg::padBits-1:0] padButtons;
	logic cmdPush;
	logic [soundPkg::cmdWidth-1:0] cmdIn;
	logic [soundPkg::cmdWidth-1:0] cmdOut;
	logic cmdPop;
	logic queueEmpty;

	// Top two address bits pick the region
	assign region = address[addrBits-1 -: 2];
	assign writeEn = en && memWrite;

	////////////////////////////////////////////////////////////////////////////
	// Processor writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			leds <= '0;
			cmdPush <= 1'b0;
		end
		else
		begin
			// Push is a single-cycle strobe
			cmdPush <= 1'b0;
			if (writeEn)
			begin
				case (region)
					ioMapPkg::regionLed:
						leds <= writeData;
					// Writing the pad region blanks the LEDs
					ioMapPkg::regionPad:
						leds <= '0;
					ioMapPkg::regionSound:
						cmdPush <= 1'b1;
					ioMapPkg::regionUnused:
						leds <= leds;
					default:
						leds <= leds;
				endcase
			end
		end
	end

	// Command code rides in the low data bits
	always_ff @(posedge clk)
	begin
		if (writeEn && (region == ioMapPkg::regionSound))
			cmdIn <= writeData[soundPkg::cmdWidth-1:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Processor reads
	////////////////////////////////////////////////////////////////////////////

	// Pad 4 lands in the top byte, pad 1 in the bottom byte
	assign ioData = address[addrBits-1] ? padButtons : '0;

	////////////////////////////////////////////////////////////////////////////
	// Pad readers
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < ioMapPkg::padCount; i++)
	begin : genPad
		nesController #(
			.tickDiv(tickDiv)
		) pad (
			.clk(clk),
			.rstN(rstN),
			.data(padData[i]),
			.latch(padLatch[i]),
			.pulse(padPulse[i]),
			.buttons(padButtons[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Sound path
	////////////////////////////////////////////////////////////////////////////

	soundCmdQueue #(
		.depth(queueDepth),
		.width(soundPkg::cmdWidth)
	) cmdQueue0 (
		.clk(clk),
		.rstN(rstN),
		.push(cmdPush),
		.dataIn(cmdIn),
		.pop(cmdPop),
		.dataOut(cmdOut),
		.empty(queueEmpty)
	);

	soundGenerator #(
		.noteCycles(noteCycles),
		.halfScale(halfScale)
	) soundGen0 (
		.clk(clk),
		.rstN(rstN),
		.cmd(cmdOut),
		.cmdReady(!queueEmpty),
		.cmdPop(cmdPop),
		.soundMelody(soundMelody),
		.soundBass(soundBass)
	);

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int periodNs = 100,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic rstN
);

	// Free-running clock, 50 % duty
	initial
	begin
		clk = 1'b0;
		forever
			#(periodNs / 2) clk = ~clk;
	end

	// Reset held low for a few edges, released on a rising edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

//--- tb/ioMemoryTb.sv
`timescale 1ns/1ps

module ioMemoryTb;

	localparam int dataWidth = ioMapPkg::defDataWidth;
	localparam int addrBits = ioMapPkg::defAddrBits;
	localparam int tickDiv = 2;
	localparam int noteCycles = 64;
	localparam int queueDepth = soundPkg::defQueueDepth;
	// Table half-periods 256 to 1024 become 2 to 8 cycles
	localparam int halfScale = 7;
	localparam int numRows = 21;

	// Row kinds, each picks the extra checks after the settle wait
	localparam int kindLeds = 0;
	localparam int kindZero = 1;
	localparam int kindPadsNew = 2;
	localparam int kindPads = 3;
	localparam int kindSndStart = 4;
	localparam int kindLaser = 5;
	localparam int kindDeath = 6;
	localparam int kindSilent = 7;

	typedef struct packed {
		logic en;
		logic memWrite;
		logic [addrBits-1:0] address;
		logic [dataWidth-1:0] writeData;
		logic [dataWidth-1:0] expLeds;
		int settle;
		int kind;
	} rowT;

	logic clk;
	logic rstN;
	logic en;
	logic memWrite;
	logic [addrBits-1:0] address;
	logic [dataWidth-1:0] writeData;
	logic [3:0] padData;
	logic [31:0] ioData;
	logic [3:0] padLatch;
	logic [3:0] padPulse;
	logic [dataWidth-1:0] leds;
	logic soundMelody;
	logic soundBass;

	rowT rows [numRows];
	logic [7:0] patterns [4];
	logic [7:0] padShift [4];
	logic [3:0] pulseSeen;
	integer seed = 31705;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	int melToggles = 0;
	int bassToggles = 0;
	logic lastMel = 1'b0;
	logic lastBass = 1'b0;
	logic [3:0] prevLatch = '0;
	logic [3:0] prevPulse = '0;
	int pulseCount [4] = '{0, 0, 0, 0};
	int framesSeen [4] = '{0, 0, 0, 0};
	int lastLatchCycle [4] = '{0, 0, 0, 0};

	clockGen #(
		.periodNs(100),
		.resetCycles(4)
	) clkGen0 (
		.clk(clk),
		.rstN(rstN)
	);

	ioMemory #(
		.dataWidth(dataWidth),
		.addrBits(addrBits),
		.tickDiv(tickDiv),
		.noteCycles(noteCycles),
		.queueDepth(queueDepth),
		.halfScale(halfScale)
	) dut0 (
		.clk(clk),
		.rstN(rstN),
		.en(en),
		.memWrite(memWrite),
		.address(address),
		.writeData(writeData),
		.padData(padData),
		.ioData(ioData),
		.padLatch(padLatch),
		.padPulse(padPulse),
		.leds(leds),
		.soundMelody(soundMelody),
		.soundBass(soundBass)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		checkCount++;
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, actual,
				expected);
			errorCount++;
		end
	endtask

	function automatic rowT makeRow(input logic rEn, input logic rWe,
		input logic [addrBits-1:0] rAddr, input logic [dataWidth-1:0] rData,
		input logic [dataWidth-1:0] rLeds, input int rSettle, input int rKind);
		rowT row;
		row.en = rEn;
		row.memWrite = rWe;
		row.address = rAddr;
		row.writeData = rData;
		row.expLeds = rLeds;
		row.settle = rSettle;
		row.kind = rKind;
		return row;
	endfunction

	// Pad 4 in the top byte down to pad 1 in the bottom byte
	function automatic logic [31:0] packedPads();
		return {patterns[3], patterns[2], patterns[1], patterns[0]};
	endfunction

	task automatic printSummary();
		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Pad models
	////////////////////////////////////////////////////////////////////////////

	// Latch loads the pattern, each pulse rise moves to the next button
	always @(posedge clk)
	begin
		for (int p = 0; p < 4; p++)
		begin
			if (padLatch[p])
				padShift[p] <= patterns[p];
			else if (padPulse[p] && !pulseSeen[p])
				padShift[p] <= padShift[p] >> 1;
			pulseSeen[p] <= padPulse[p];
		end
	end

	// Lines are active low
	for (genvar g = 0; g < 4; g++)
	begin : genPadLine
		assign padData[g] = ~padShift[g][0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitors, sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	// One latch then seven pulses per frame, latches one frame apart
	always @(negedge clk)
	begin
		for (int p = 0; p < 4; p++)
		begin
			if (padLatch[p] && !prevLatch[p])
			begin
				if (framesSeen[p] > 0)
				begin
					checkValue(pulseCount[p], 7, $sformatf("pad %0d pulses per frame", p));
					checkValue(cycleCount - lastLatchCycle[p], 32 * tickDiv,
						$sformatf("pad %0d latch spacing", p));
				end
				pulseCount[p] = 0;
				lastLatchCycle[p] = cycleCount;
				framesSeen[p]++;
			end
			if (padPulse[p] && !prevPulse[p])
				pulseCount[p]++;
		end
		prevLatch = padLatch;
		prevPulse = padPulse;
	end

	// Pin edges
	always @(negedge clk)
	begin
		if (soundMelody !== lastMel)
			melToggles++;
		if (soundBass !== lastBass)
			bassToggles++;
		lastMel = soundMelody;
		lastBass = soundBass;
	end

	// Cycle limit
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("Timeout: the run went past %0d clock cycles", cycleLimit);
			printSummary();
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table and main sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic applyRow(input rowT row);
		if (row.kind == kindPadsNew)
		begin
			for (int p = 0; p < 4; p++)
				patterns[p] = $random(seed);
		end
		// Every sound row counts its own pin edges
		if (row.kind >= kindSndStart)
		begin
			melToggles = 0;
			bassToggles = 0;
		end
		@(posedge clk);
		en <= row.en;
		memWrite <= row.memWrite;
		address <= row.address;
		writeData <= row.writeData;
		// Inputs seen for exactly settle edges
		repeat (row.settle) @(posedge clk);
		en <= 1'b0;
		memWrite <= 1'b0;
		@(negedge clk);
		checkValue(leds, row.expLeds, "leds");
		case (row.kind)
			kindZero:
				checkValue(ioData, 32'h0, "ioData low region");
			kindPadsNew, kindPads:
				checkValue(ioData, packedPads(), "ioData pad word");
			kindLaser:
			begin
				checkValue(melToggles > 0, 1'b1, "laser melody toggles");
				checkValue(bassToggles, 0, "laser bass toggles");
			end
			kindDeath:
			begin
				checkValue(melToggles > 0, 1'b1, "death melody toggles");
				checkValue(bassToggles > 0, 1'b1, "death bass toggles");
			end
			kindSilent:
			begin
				checkValue(melToggles, 0, "silent melody toggles");
				checkValue(bassToggles, 0, "silent bass toggles");
			end
			default:
				;
		endcase
		if (row.kind >= kindLaser)
		begin
			checkValue(soundMelody, 1'b0, "melody low after command");
			checkValue(soundBass, 1'b0, "bass low after command");
		end
	endtask

	initial
	begin
		int totalCycles;
		en = 1'b0;
		memWrite = 1'b0;
		address = '0;
		writeData = '0;
		pulseSeen = '0;
		for (int p = 0; p < 4; p++)
		begin
			patterns[p] = 8'h00;
			padShift[p] = 8'h00;
		end

		// LED writes, gated writes and the pad region clear
		rows[0] = makeRow(1, 1, 14'h1000, 8'h5a, 8'h5a, 1, kindLeds);
		rows[1] = makeRow(0, 1, 14'h1004, 8'hff, 8'h5a, 1, kindLeds);
		rows[2] = makeRow(1, 0, 14'h1fff, 8'hff, 8'h5a, 1, kindLeds);
		rows[3] = makeRow(1, 1, 14'h0123, 8'hff, 8'h5a, 1, kindZero);
		rows[4] = makeRow(1, 1, 14'h1abc, 8'ha5, 8'ha5, 1, kindLeds);
		rows[5] = makeRow(1, 1, 14'h3fff, 8'h77, 8'h00, 1, kindLeds);
		rows[6] = makeRow(1, 1, 14'h1001, 8'h3c, 8'h3c, 1, kindLeds);
		// Two frames are 128 cycles
		rows[7] = makeRow(1, 0, 14'h3000, 8'h00, 8'h3c, 140, kindPadsNew);
		rows[8] = makeRow(1, 0, 14'h2abc, 8'h00, 8'h3c, 1, kindPads);
		rows[9] = makeRow(1, 0, 14'h3ffe, 8'h00, 8'h3c, 140, kindPadsNew);
		rows[10] = makeRow(1, 0, 14'h2001, 8'h00, 8'h3c, 1, kindPads);
		// One command is 256 cycles
		rows[11] = makeRow(1, 1, 14'h2000, 8'(soundPkg::cmdLaser), 8'h3c, 1, kindSndStart);
		rows[12] = makeRow(0, 0, 14'h0000, 8'h00, 8'h3c, 260, kindLaser);
		// Held two edges, so two pushes back to back
		rows[13] = makeRow(1, 1, 14'h2100, 8'(soundPkg::cmdDeath), 8'h3c, 2, kindSndStart);
		// First command done, queued one popped but its tones not yet started
		rows[14] = makeRow(0, 0, 14'h0000, 8'h00, 8'h3c, 258, kindDeath);
		// Second command out of the queue, played to the end
		rows[15] = makeRow(0, 0, 14'h0000, 8'h00, 8'h3c, 258, kindDeath);
		rows[16] = makeRow(1, 1, 14'h2fff, 8'h00, 8'h3c, 1, kindSndStart);
		rows[17] = makeRow(0, 0, 14'h0000, 8'h00, 8'h3c, 260, kindSilent);
		rows[18] = makeRow(1, 1, 14'h2002, 8'h02, 8'h3c, 1, kindSndStart);
		rows[19] = makeRow(0, 0, 14'h0000, 8'h00, 8'h3c, 260, kindSilent);
		rows[20] = makeRow(1, 1, 14'h1111, 8'h81, 8'h81, 1, kindLeds);

		// Each row costs its settle edges plus the drive edge
		totalCycles = 5;
		for (int r = 0; r < numRows; r++)
			totalCycles += rows[r].settle + 1;
		cycleLimit = totalCycles * 6 / 5;

		// Reset state
		wait (rstN === 1'b1);
		@(negedge clk);
		checkValue(leds, '0, "leds after reset");
		checkValue(padLatch, 4'h0, "latch after reset");
		checkValue(padPulse, 4'h0, "pulse after reset");
		checkValue(soundMelody, 1'b0, "melody after reset");
		checkValue(soundBass, 1'b0, "bass after reset");
		checkValue(ioData, 32'h0, "ioData after reset");

		for (int r = 0; r < numRows; r++)
			applyRow(rows[r]);

		for (int p = 0; p < 4; p++)
			checkValue(framesSeen[p] > 4, 1'b1, $sformatf("pad %0d frames seen", p));

		printSummary();
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- src.f
design/ioMapPkg.sv
design/soundPkg.sv
design/nesController.sv
design/soundCmdQueue.sv
design/soundGenerator.sv
design/ioMemory.sv
tb/clockGen.sv
tb/ioMemoryTb.sv
